/* hw/countConnected_defs.svh */
`ifndef COUNT_CONNECTED_DEFS_SVH
`define COUNT_CONNECTED_DEFS_SVH

// One bit per vertex of the 7-cube
`define GRAPH_BITS 128
`define VERTEX_BITS 7

// Largest antichain of the 7-cube has 35 members
`define COUNT_BITS 6
`define TAG_BITS 8

// Input credits
`define QUEUE_DEPTH 4

// Closure pipeline
`define CLOSURE_STEPS_PER_REG 2
`define CLOSURE_LATENCY ((`VERTEX_BITS + `CLOSURE_STEPS_PER_REG - 1) / `CLOSURE_STEPS_PER_REG)

// Ring delays
`define SEED_LATENCY 3
`define EXPLORE_LATENCY (4 * `CLOSURE_LATENCY + 5)
`define LOOP_DELAY 3
`define RING_SLOTS (`SEED_LATENCY + `EXPLORE_LATENCY + `LOOP_DELAY)

`endif

/* hw/countConnectedPkg.sv */
`include "countConnected_defs.svh"

package countConnectedPkg;

    // Bit k is set when vertex k is present
    typedef logic [`GRAPH_BITS-1:0] graphT;
    typedef logic [`COUNT_BITS-1:0] countT;
    typedef logic [`TAG_BITS-1:0] tagT;

    typedef struct packed {
        graphT graph;
        tagT tag;
    } graphJobT;

    typedef struct packed {
        countT count;
        tagT tag;
    } countResultT;

    // Per-slot bookkeeping that circulates beside the graph words
    typedef struct packed {
        logic valid;
        countT count;
        tagT tag;
    } slotStateT;

endpackage

/* hw/delayLine.sv */
`timescale 1ns/10ps

module delayLine #(
    parameter int CYCLES = 1,
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] stages [CYCLES];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < CYCLES; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= d;
            for (int i = 1; i < CYCLES; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign q = stages[CYCLES-1];

endmodule

/* hw/graphInputQueue.sv */
`timescale 1ns/10ps
`include "countConnected_defs.svh"

module graphInputQueue
    import countConnectedPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     jobValid,
    input  graphJobT job,
    input  logic     pop,
    output logic     jobReady,
    output graphJobT head,
    output logic     credit
);

    localparam int PTR_BITS = $clog2(`QUEUE_DEPTH);
    localparam int OCC_BITS = $clog2(`QUEUE_DEPTH + 1);

    graphJobT entries [`QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS-1:0] rdPtr;
    logic [OCC_BITS-1:0] occupancy;
    logic [OCC_BITS-1:0] startCredits;
    logic startDone;

    function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(`QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (jobValid) begin
            entries[wrPtr] <= job;
        end
    end

    // One credit per entry after reset, then one per pop
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            occupancy <= '0;
            startCredits <= OCC_BITS'(`QUEUE_DEPTH);
            credit <= 1'b0;
        end else begin
            if (jobValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            occupancy <= occupancy + OCC_BITS'(jobValid) - OCC_BITS'(pop);
            if (!startDone) begin
                startCredits <= startCredits - OCC_BITS'(1);
            end
            credit <= !startDone || pop;
        end
    end

    // Pops wait for the start-up credits so the two credit sources never collide
    assign startDone = (startCredits == '0);
    assign jobReady = startDone && (occupancy != '0);
    assign head = entries[rdPtr];

    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        jobValid |-> occupancy != OCC_BITS'(`QUEUE_DEPTH))
        else $error("job pushed without a credit into a full queue");

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        pop |-> occupancy != '0)
        else $error("pop from an empty input queue");

endmodule

/* hw/firstBitFinder.sv */
`timescale 1ns/10ps
`include "countConnected_defs.svh"

module firstBitFinder
    import countConnectedPkg::*;
(
    input  logic  clk,
    input  graphT graph,
    output graphT firstOneHot,
    output logic  isEmpty
);

    localparam int GROUPS4 = `GRAPH_BITS / 4;
    localparam int GROUPS16 = `GRAPH_BITS / 16;

    graphT graphD;
    logic [GROUPS4-1:0] has4D;
    logic [GROUPS16-1:0] has16D;
    logic [GROUPS16-1:0] first16;
    logic [GROUPS4-1:0] first4;
    graphT oneHot;

    // Occupancy of every 4-bit and 16-bit group in the first stage
    always_ff @(posedge clk) begin
        graphD <= graph;
        for (int g = 0; g < GROUPS4; g++) begin
            has4D[g] <= |graph[4*g +: 4];
        end
        for (int i = 0; i < GROUPS16; i++) begin
            has16D[i] <= |graph[16*i +: 16];
        end
    end

    // Prefix masks from coarse to fine in the second stage
    always_comb begin
        logic clear;
        clear = 1'b1;
        for (int i = 0; i < GROUPS16; i++) begin
            first16[i] = clear;
            clear = clear & ~has16D[i];
        end
        for (int i = 0; i < GROUPS16; i++) begin
            clear = first16[i];
            for (int j = 0; j < 4; j++) begin
                first4[4*i+j] = clear;
                clear = clear & ~has4D[4*i+j];
            end
        end
        // Only the lowest non-empty 4-bit group is still enabled here
        for (int g = 0; g < GROUPS4; g++) begin
            clear = first4[g];
            for (int b = 0; b < 4; b++) begin
                oneHot[4*g+b] = clear & graphD[4*g+b];
                clear = clear & ~graphD[4*g+b];
            end
        end
    end

    always_ff @(posedge clk) begin
        firstOneHot <= oneHot;
        isEmpty <= ~|has16D;
    end

endmodule

/* hw/seedSelector.sv */
`timescale 1ns/10ps
`include "countConnected_defs.svh"

module seedSelector
    import countConnectedPkg::*;
(
    input  logic  clk,
    input  graphT leftover,
    input  graphT extended,
    input  logic  grabSeed,
    output graphT leftoverOut,
    output graphT frontierOut,
    output logic  increment
);

    graphT firstOneHot;
    logic isEmpty;
    graphT leftoverAligned;
    graphT extendedAligned;
    logic grabAligned;

    // Lowest present vertex becomes the seed
    firstBitFinder finder (
        .clk(clk),
        .graph(leftover),
        .firstOneHot(firstOneHot),
        .isEmpty(isEmpty)
    );

    // Hold the loop inputs until the finder result is ready
    delayLine #(
        .CYCLES(`SEED_LATENCY - 1),
        .WIDTH(2 * `GRAPH_BITS + 1)
    ) alignDelay (
        .clk(clk),
        .rstN(1'b1),
        .d({leftover, extended, grabSeed}),
        .q({leftoverAligned, extendedAligned, grabAligned})
    );

    always_ff @(posedge clk) begin
        leftoverOut <= leftoverAligned;
        frontierOut <= grabAligned ? firstOneHot : extendedAligned;
        // A new component starts only if something is left
        increment <= grabAligned && !isEmpty;
    end

endmodule

/* hw/monotoneClosure.sv */
`timescale 1ns/10ps
`include "countConnected_defs.svh"

module monotoneClosure
    import countConnectedPkg::*;
#(
    parameter bit UPWARD = 1'b1
) (
    input  logic  clk,
    input  graphT set,
    output graphT closed
);

    localparam int DIMS = `VERTEX_BITS;
    localparam int STEPS = `CLOSURE_STEPS_PER_REG;
    localparam int STAGES = `CLOSURE_LATENCY;

    graphT stageRegs [STAGES];

    // Adds every vertex reachable by flipping dimension d in the closure direction
    function automatic graphT crossDim(graphT s, int d);
        graphT moved;
        for (int v = 0; v < `GRAPH_BITS; v++) begin
            if (v[d] == UPWARD) begin
                moved[v] = s[v ^ (1 << d)];
            end else begin
                moved[v] = 1'b0;
            end
        end
        return s | moved;
    endfunction

    for (genvar st = 0; st < STAGES; st++) begin : gStage
        graphT stageIn;
        graphT stageOut;

        if (st == 0) begin : gHead
            assign stageIn = set;
        end else begin : gTail
            assign stageIn = stageRegs[st-1];
        end

        // Last stage may carry fewer dimensions
        always_comb begin
            stageOut = stageIn;
            for (int k = 0; k < STEPS; k++) begin
                if (st * STEPS + k < DIMS) begin
                    stageOut = crossDim(stageOut, st * STEPS + k);
                end
            end
        end

        always_ff @(posedge clk) begin
            stageRegs[st] <= stageOut;
        end
    end

    assign closed = stageRegs[STAGES-1];

endmodule

/* hw/componentExplorer.sv */
`timescale 1ns/10ps
`include "countConnected_defs.svh"

module componentExplorer
    import countConnectedPkg::*;
(
    input  logic  clk,
    input  graphT leftover,
    input  graphT frontier,
    output graphT reduced,
    output graphT extended,
    output logic  grabSeed,
    output logic  runEnd
);

    graphT leftA;
    graphT leftB;
    graphT leftC;
    graphT leftD;
    graphT closedA;
    graphT closedB;
    graphT closedC;
    graphT closedD;
    graphT grownA;
    graphT grownB;
    graphT midpoint;
    graphT midpointD;
    graphT reducedR;
    graphT extendedR;

    // Leftover copies lined up with each closure output
    delayLine #(.CYCLES(`CLOSURE_LATENCY), .WIDTH(`GRAPH_BITS)) leftDelayA (
        .clk(clk), .rstN(1'b1), .d(leftover), .q(leftA)
    );
    delayLine #(.CYCLES(`CLOSURE_LATENCY + 1), .WIDTH(`GRAPH_BITS)) leftDelayB (
        .clk(clk), .rstN(1'b1), .d(leftA), .q(leftB)
    );
    delayLine #(.CYCLES(`CLOSURE_LATENCY + 1), .WIDTH(`GRAPH_BITS)) leftDelayC (
        .clk(clk), .rstN(1'b1), .d(leftB), .q(leftC)
    );
    delayLine #(.CYCLES(`CLOSURE_LATENCY + 1), .WIDTH(`GRAPH_BITS)) leftDelayD (
        .clk(clk), .rstN(1'b1), .d(leftC), .q(leftD)
    );

    monotoneClosure #(.UPWARD(1'b1)) closeUpA (
        .clk(clk), .set(frontier), .closed(closedA)
    );
    monotoneClosure #(.UPWARD(1'b0)) closeDownB (
        .clk(clk), .set(grownA), .closed(closedB)
    );
    monotoneClosure #(.UPWARD(1'b1)) closeUpC (
        .clk(clk), .set(grownB), .closed(closedC)
    );
    monotoneClosure #(.UPWARD(1'b0)) closeDownD (
        .clk(clk), .set(midpoint), .closed(closedD)
    );

    // Midpoint waits for the last closure to compare against it
    delayLine #(.CYCLES(`CLOSURE_LATENCY + 1), .WIDTH(`GRAPH_BITS)) midDelay (
        .clk(clk), .rstN(1'b1), .d(midpoint), .q(midpointD)
    );

    always_ff @(posedge clk) begin
        grownA <= closedA & leftA;
        grownB <= closedB & leftB;
        midpoint <= closedC & leftC;
        reducedR <= leftD & ~closedD;
        extendedR <= leftD & closedD;
    end

    // Growth stopped once the last down-closure adds nothing to the midpoint
    always_ff @(posedge clk) begin
        reduced <= reducedR;
        extended <= extendedR;
        runEnd <= (reducedR == '0);
        grabSeed <= (extendedR == midpointD) || (reducedR == '0);
    end

endmodule

/* hw/countConnectedCore.sv */
`timescale 1ns/10ps
`include "countConnected_defs.svh"

module countConnectedCore
    import countConnectedPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        jobValid,
    input  graphJobT    job,
    output logic        credit,
    output logic        resultValid,
    output countResultT result
);

    graphJobT head;
    logic jobReady;
    logic pop;
    logic slotDone;
    graphT loadGraph;
    graphT entryLeftover;
    logic grabSeedEntry;

    graphT reducedBack;
    graphT extendedBack;
    logic runEndBack;
    logic grabSeedBack;

    graphT selLeftover;
    graphT selFrontier;
    logic increment;

    graphT reducedOut;
    graphT extendedOut;
    logic runEndOut;
    logic grabSeedOut;

    slotStateT stateBack;
    slotStateT entryState;
    slotStateT stateSeed;
    slotStateT stateNext;

    graphInputQueue inputQueue (
        .clk(clk),
        .rstN(rstN),
        .jobValid(jobValid),
        .job(job),
        .pop(pop),
        .jobReady(jobReady),
        .head(head),
        .credit(credit)
    );

    // At ring entry an invalid slot counts as finished so it can take a job
    assign slotDone = runEndBack || !stateBack.valid;
    assign pop = slotDone && jobReady;
    assign loadGraph = jobReady ? head.graph : '0;
    assign entryLeftover = slotDone ? loadGraph : reducedBack;
    assign grabSeedEntry = slotDone || grabSeedBack;

    always_comb begin
        entryState = stateBack;
        if (slotDone) begin
            entryState.valid = jobReady;
            entryState.count = '0;
            entryState.tag = head.tag;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= runEndBack && stateBack.valid;
        end
    end

    always_ff @(posedge clk) begin
        result.count <= stateBack.count;
        result.tag <= stateBack.tag;
    end

    seedSelector selector (
        .clk(clk),
        .leftover(entryLeftover),
        .extended(extendedBack),
        .grabSeed(grabSeedEntry),
        .leftoverOut(selLeftover),
        .frontierOut(selFrontier),
        .increment(increment)
    );

    componentExplorer explorer (
        .clk(clk),
        .leftover(selLeftover),
        .frontier(selFrontier),
        .reduced(reducedOut),
        .extended(extendedOut),
        .grabSeed(grabSeedOut),
        .runEnd(runEndOut)
    );

    // Loopback of graph words and flags
    delayLine #(.CYCLES(`LOOP_DELAY), .WIDTH(`GRAPH_BITS)) reducedLoop (
        .clk(clk), .rstN(1'b1), .d(reducedOut), .q(reducedBack)
    );
    delayLine #(.CYCLES(`LOOP_DELAY), .WIDTH(`GRAPH_BITS)) extendedLoop (
        .clk(clk), .rstN(1'b1), .d(extendedOut), .q(extendedBack)
    );
    delayLine #(.CYCLES(`LOOP_DELAY), .WIDTH(2)) flagLoop (
        .clk(clk), .rstN(1'b1), .d({runEndOut, grabSeedOut}), .q({runEndBack, grabSeedBack})
    );

    // Slot state meets the increment after the seed stage
    delayLine #(.CYCLES(`SEED_LATENCY), .WIDTH($bits(slotStateT))) stateSeedDelay (
        .clk(clk), .rstN(rstN), .d(entryState), .q(stateSeed)
    );

    always_comb begin
        stateNext = stateSeed;
        stateNext.count = stateSeed.count + countT'(increment);
    end

    delayLine #(
        .CYCLES(`RING_SLOTS - `SEED_LATENCY),
        .WIDTH($bits(slotStateT))
    ) stateLoop (
        .clk(clk), .rstN(rstN), .d(stateNext), .q(stateBack)
    );

    countNoWrap: assert property (@(posedge clk) disable iff (!rstN)
        (stateSeed.valid && increment) |-> stateSeed.count != '1)
        else $error("component count overflow in slot with tag %0h", stateSeed.tag);

endmodule

/* test/tbClock.sv */
`timescale 1ns/10ps

module tbClock (
    output logic clk,
    output logic rstN
);

    localparam int RESET_CYCLES = 16;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release on a falling edge away from the flops
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

/* test/countConnectedTb.sv */
`timescale 1ns/10ps
`include "countConnected_defs.svh"

module countConnectedTb
    import countConnectedPkg::*;
();

    localparam int TIMEOUT_CYCLES = 30000;
    localparam int TAG_COUNT = 1 << `TAG_BITS;
    localparam int RANDOM_JOBS = 40;

    logic clk;
    logic rstN;
    logic jobValid;
    graphJobT job;
    logic credit;
    logic resultValid;
    countResultT result;

    int errorCount = 0;
    bit timedOut = 1'b0;
    int creditsReceived = 0;
    int jobsSent = 0;
    int resultsSeen = 0;
    int inFlight = 0;
    int maxInFlight = 0;
    countResultT lastResult;
    logic [31:0] lfsrState = 32'h2371264a;

    // Scoreboard indexed by tag
    bit tagPending [TAG_COUNT];
    int tagReturns [TAG_COUNT];
    countT tagCount [TAG_COUNT];
    countT expectedCount [TAG_COUNT];

    tbClock clockGen (
        .clk(clk),
        .rstN(rstN)
    );

    countConnectedCore countConnectedCore_i (
        .clk(clk),
        .rstN(rstN),
        .jobValid(jobValid),
        .job(job),
        .credit(credit),
        .resultValid(resultValid),
        .result(result)
    );

    // Registered DUT outputs are sampled on the rising edge
    always @(posedge clk) begin
        if (rstN) begin
            if (credit) begin
                creditsReceived++;
                if (creditsReceived - jobsSent > `QUEUE_DEPTH) begin
                    errorCount++;
                    $display("Source holds %0d credits at %0t, more than the queue depth",
                        creditsReceived - jobsSent, $time);
                end
            end
            if (resultValid) begin
                resultsSeen++;
                lastResult = result;
                tagReturns[result.tag]++;
                tagCount[result.tag] = result.count;
                if (tagPending[result.tag]) begin
                    tagPending[result.tag] = 1'b0;
                    inFlight--;
                end else begin
                    errorCount++;
                    $display("Result at %0t carries tag %02h with no job in flight",
                        $time, result.tag);
                end
            end
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2, 1
    function automatic logic nextRandomBit();
        logic feedback;
        feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    // Each vertex is the AND of density random bits
    function automatic graphT randomGraph(int density);
        graphT graph;
        logic present;
        for (int v = 0; v < `GRAPH_BITS; v++) begin
            present = 1'b1;
            for (int k = 0; k < density; k++) begin
                present = present & nextRandomBit();
            end
            graph[v] = present;
        end
        return graph;
    endfunction

    function automatic bit comparable(int a, int b);
        return ((a & b) == a) || ((a & b) == b);
    endfunction

    // Breadth-first search over present vertices
    function automatic int referenceCount(graphT graph);
        bit visited [`GRAPH_BITS];
        int frontier [$];
        int components;
        int v;
        components = 0;
        foreach (visited[i]) begin
            visited[i] = 1'b0;
        end
        for (int s = 0; s < `GRAPH_BITS; s++) begin
            if (graph[s] && !visited[s]) begin
                components++;
                visited[s] = 1'b1;
                frontier.push_back(s);
                while (frontier.size() > 0) begin
                    v = frontier.pop_front();
                    for (int u = 0; u < `GRAPH_BITS; u++) begin
                        if (graph[u] && !visited[u] && comparable(v, u)) begin
                            visited[u] = 1'b1;
                            frontier.push_back(u);
                        end
                    end
                end
            end
        end
        return components;
    endfunction

    task automatic compareCount(input string name, input countT actual, input countT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL time %0t %s: got %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic compareTag(input string name, input tagT actual, input tagT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL time %0t %s: got %02h, expected %02h", $time, name, actual, expected);
        end
    endtask

    task automatic reportTimeout(input string what);
        errorCount++;
        timedOut = 1'b1;
        $display("Timeout after %0d cycles while %s", TIMEOUT_CYCLES, what);
    endtask

    task automatic waitForReset();
        int waited;
        waited = 0;
        while (rstN !== 1'b1 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (rstN !== 1'b1) begin
            reportTimeout("waiting for reset release");
        end
        @(negedge clk);
    endtask

    // Starts and returns on a falling edge
    task automatic sendJob(input graphT graph, input tagT tag);
        int waited;
        waited = 0;
        if (timedOut) return;
        while (creditsReceived - jobsSent == 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (creditsReceived - jobsSent == 0) begin
            reportTimeout("waiting for an input credit");
            return;
        end
        expectedCount[tag] = countT'(referenceCount(graph));
        tagPending[tag] = 1'b1;
        inFlight++;
        if (inFlight > maxInFlight) begin
            maxInFlight = inFlight;
        end
        jobsSent++;
        jobValid = 1'b1;
        job.graph = graph;
        job.tag = tag;
        @(negedge clk);
        jobValid = 1'b0;
    endtask

    task automatic waitIdle(input string what);
        int waited;
        waited = 0;
        if (timedOut) return;
        while (inFlight != 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (inFlight != 0) begin
            reportTimeout(what);
        end
    endtask

    // Waits for the next resultValid pulse, whatever its tag
    task automatic waitForResult(input int seenBefore, input string what);
        int waited;
        waited = 0;
        if (timedOut) return;
        while (resultsSeen == seenBefore && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (resultsSeen == seenBefore) begin
            reportTimeout(what);
        end
    endtask

    task automatic runSingleJob(input string name, input graphT graph, input tagT tag,
                                input countT expected);
        int refCount;
        int seenBefore;
        refCount = referenceCount(graph);
        if (timedOut) return;
        if (refCount != int'(expected)) begin
            errorCount++;
            $display("Reference count %0d for %s differs from the expected %0d",
                refCount, name, expected);
        end
        seenBefore = resultsSeen;
        sendJob(graph, tag);
        waitForResult(seenBefore, {"waiting for the result of ", name});
        if (timedOut) return;
        compareTag({"result.tag (", name, ")"}, lastResult.tag, tag);
        compareCount({"result.count (", name, ")"}, lastResult.count, expected);
    endtask

    // Start-up credits arrive in the first cycles and the ring stays quiet
    task automatic checkResetCredits();
        if (timedOut) return;
        repeat (2 * `RING_SLOTS) @(negedge clk);
        if (creditsReceived != `QUEUE_DEPTH) begin
            errorCount++;
            $display("Received %0d credits after reset instead of %0d",
                creditsReceived, `QUEUE_DEPTH);
        end
        if (resultsSeen != 0) begin
            errorCount++;
            $display("Saw %0d results before any job was sent", resultsSeen);
        end
    endtask

    task automatic checkSmallGraphs();
        graphT single;
        single = '0;
        single[37] = 1'b1;
        runSingleJob("empty graph", '0, 8'h01, countT'(0));
        runSingleJob("single vertex", single, 8'h02, countT'(1));
    endtask

    task automatic checkFixedGraphs();
        graphT pair;
        graphT chain;
        graphT weightThree;
        pair = '0;
        pair[1] = 1'b1;
        pair[2] = 1'b1;
        chain = '0;
        chain[0] = 1'b1;
        chain[1] = 1'b1;
        chain[3] = 1'b1;
        chain[7] = 1'b1;
        for (int v = 0; v < `GRAPH_BITS; v++) begin
            weightThree[v] = ($countones(v) == 3);
        end
        runSingleJob("vertices 1 and 2", pair, 8'h03, countT'(2));
        runSingleJob("chain 0 1 3 7", chain, 8'h04, countT'(1));
        runSingleJob("full graph", '1, 8'h05, countT'(1));
        // Weight-3 level is an antichain of 35 vertices
        runSingleJob("weight-3 level", weightThree, 8'h06, countT'(35));
    endtask

    task automatic checkRandomBurst();
        tagT tag;
        if (timedOut) return;
        for (int i = 0; i < RANDOM_JOBS; i++) begin
            sendJob(randomGraph(i % 3 + 1), tagT'(8'h40 + i));
        end
        waitIdle("waiting for the random graphs to return");
        if (timedOut) return;
        if (maxInFlight < 2) begin
            errorCount++;
            $display("Random burst never had more than one graph in flight");
        end
        for (int i = 0; i < RANDOM_JOBS; i++) begin
            tag = tagT'(8'h40 + i);
            if (tagReturns[tag] != 1) begin
                errorCount++;
                $display("Tag %02h returned %0d times instead of once", tag, tagReturns[tag]);
            end else begin
                compareCount($sformatf("result.count (tag %02h)", tag), tagCount[tag],
                    expectedCount[tag]);
            end
        end
    endtask

    task automatic checkCreditAccounting();
        if (timedOut) return;
        // Last credit follows its pop by one cycle
        repeat (4) @(negedge clk);
        if (creditsReceived != `QUEUE_DEPTH + jobsSent) begin
            errorCount++;
            $display("Received %0d credits for %0d jobs, expected %0d",
                creditsReceived, jobsSent, `QUEUE_DEPTH + jobsSent);
        end
    endtask

    initial begin
        jobValid = 1'b0;
        job = '0;
        waitForReset();
        checkResetCredits();
        checkSmallGraphs();
        checkFixedGraphs();
        checkRandomBurst();
        checkCreditAccounting();
        $display("Tests finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+hw
hw/countConnectedPkg.sv
hw/delayLine.sv
hw/graphInputQueue.sv
hw/firstBitFinder.sv
hw/seedSelector.sv
hw/monotoneClosure.sv
hw/componentExplorer.sv
hw/countConnectedCore.sv
test/tbClock.sv
test/countConnectedTb.sv

/* run.sh */
#!/bin/sh
# Builds the countConnectedCore testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module countConnectedTb \
    -o countConnectedSim

./obj_dir/countConnectedSim 2>&1 | tee "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

echo "Simulation log is clean"
exit 0
